/* cpu_settings.svh */
/*
  widths and reset PC shared by the front end package and RTL.
  include wherever a macro below is needed.
*/
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data and address width.
`define WORD_W 32

// register number width, 32 registers.
`define REG_W 5

// first fetch address after reset.
`define RESET_PC 32'h0000_0000

`endif

/* cpu_types_pkg.sv */
/*
  types shared between fetch, the IF/ID register and decode.
  opcode and funct values follow the MIPS encoding.
*/
`include "cpu_settings.svh"

package cpu_types_pkg;

	typedef logic [`REG_W-1:0]  regbits_t;	// register number.
	typedef logic [`WORD_W-1:0] word_t;	// data or address word.

	typedef enum logic [5:0] {
		RTYPE = 6'h00, J     = 6'h02, JAL   = 6'h03, BEQ   = 6'h04,
		BNE   = 6'h05, ADDI  = 6'h08, ADDIU = 6'h09, SLTI  = 6'h0a,
		SLTIU = 6'h0b, ANDI  = 6'h0c, ORI   = 6'h0d, XORI  = 6'h0e,
		LUI   = 6'h0f, LW    = 6'h23, SW    = 6'h2b, HALT  = 6'h3f
	} opcode_t;

	typedef enum logic [5:0] {
		SLL  = 6'h00, SRL  = 6'h02, JR   = 6'h08, ADD  = 6'h20,
		ADDU = 6'h21, SUB  = 6'h22, SUBU = 6'h23, AND  = 6'h24,
		OR   = 6'h25, XOR  = 6'h26, NOR  = 6'h27, SLT  = 6'h2a,
		SLTU = 6'h2b
	} funct_t;

	typedef enum logic [3:0] {
		ALU_SLL, ALU_SRL, ALU_ADD, ALU_SUB,
		ALU_AND, ALU_OR,  ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_LUI	// lui passes imm32 through.
	} aluop_t;

	// contents of the IF/ID register, msb first.
	typedef struct packed {
		logic         valid;	// 0 for reset and bubbles.
		opcode_t      opcode;
		regbits_t     rs;
		regbits_t     rt;
		regbits_t     rd;
		logic [4:0]   shamt;
		funct_t       funct;
		logic [15:0]  imm16;
		logic [25:0]  jaddr26;
		word_t        pc_plus4;	// return address for jal.
	} if_id_t;

	// control word from decode.
	typedef struct packed {
		aluop_t alu_op;
		logic   reg_write;
		logic   mem_read;
		logic   mem_write;
		logic   alu_src_imm;	// operand b is imm32.
		logic   reg_dst_rd;	// write rd, else rt.
		logic   branch;
		logic   branch_ne;	// with branch, taken on not equal.
		logic   jump;
		logic   jump_reg;
		logic   link;	// write pc_plus4 to $31.
		logic   halt;
		logic   illegal;
	} ctrl_t;

endpackage

/* pc_fetch.sv */
/*
  program counter and fetch control; drives the instruction memory address
  and the load and flush levels of the IF/ID register.
*/
`timescale 1ns/1ns
`include "cpu_settings.svh"

module pc_fetch
	import cpu_types_pkg::*;
(
	input  logic  CLK,
	input  logic  nRST,
	input  logic  ihit,
	input  logic  stall,
	input  logic  redirect,
	input  word_t redirect_pc,
	output word_t imem_addr,
	output word_t pc_plus4,
	output logic  advance,
	output logic  flush
);

	word_t pc;	// address of the word being fetched.

	assign imem_addr = pc;	// memory sees the pc directly.
	assign pc_plus4  = pc + `WORD_W'(4);	// next sequential word.

	// redirect wins over stall and over a hit.
	assign advance = ihit & ~stall & ~redirect;
	assign flush   = redirect;	// wrong-path word is dropped.

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			pc <= `RESET_PC;
		end else if (redirect) begin
			pc <= redirect_pc;	// branch or jump target from downstream.
		end else if (advance) begin
			pc <= pc_plus4;
		end
		// miss or stall holds the pc, the same word is fetched again.
	end

endmodule

/* if_id_reg.sv */
/*
  IF/ID pipeline register; splits the fetched word into its fields.
  advance loads a new word, flush loads a bubble, otherwise it holds.
*/
`timescale 1ns/1ns

module if_id_reg
	import cpu_types_pkg::*;
(
	input  logic   CLK,
	input  logic   nRST,
	input  logic   advance,
	input  logic   flush,
	input  word_t  instruction,
	input  word_t  pc_plus4,
	output if_id_t if_id
);

	// canonical nop, add $0,$0,$0 with valid low.
	localparam if_id_t bubble = '{
		valid:  1'b0,
		opcode: RTYPE,
		funct:  ADD,
		default: '0
	};

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			if_id <= '0;	// valid low, decode outputs zero.
		end else if (flush) begin
			if_id <= bubble;
		end else if (advance) begin
			if_id <= '{
				valid:    1'b1,
				opcode:   opcode_t'(instruction[31:26]),
				rs:       instruction[25:21],
				rt:       instruction[20:16],
				rd:       instruction[15:11],
				shamt:    instruction[10:6],
				funct:    funct_t'(instruction[5:0]),
				imm16:    instruction[15:0],
				jaddr26:  instruction[25:0],
				pc_plus4: pc_plus4	// of the pc that fetched this word.
			};
		end
	end

endmodule

/* control_decode.sv */
/*
  combinational decode of the IF/ID fields into the control word and the
  extended immediate; a bubble gives all zero outputs.
*/
`timescale 1ns/1ns

module control_decode
	import cpu_types_pkg::*;
(
	input  if_id_t if_id,
	output ctrl_t  ctrl,
	output word_t  imm32
);

	word_t imm_sext;	// sign extended imm16.
	word_t imm_zext;	// zero extended imm16.

	assign imm_sext = {{16{if_id.imm16[15]}}, if_id.imm16};
	assign imm_zext = {16'h0000, if_id.imm16};

	always_comb begin
		ctrl  = '0;
		imm32 = '0;
		if (if_id.valid) begin	// bubbles keep everything zero.
			case (if_id.opcode)
				RTYPE: begin
					ctrl.reg_dst_rd = 1'b1;
					ctrl.reg_write  = 1'b1;
					case (if_id.funct)
						SLL:  ctrl.alu_op = ALU_SLL;
						SRL:  ctrl.alu_op = ALU_SRL;
						ADD, ADDU: ctrl.alu_op = ALU_ADD;
						SUB, SUBU: ctrl.alu_op = ALU_SUB;
						AND:  ctrl.alu_op = ALU_AND;
						OR:   ctrl.alu_op = ALU_OR;
						XOR:  ctrl.alu_op = ALU_XOR;
						NOR:  ctrl.alu_op = ALU_NOR;
						SLT:  ctrl.alu_op = ALU_SLT;
						SLTU: ctrl.alu_op = ALU_SLTU;
						JR: begin
							ctrl            = '0;	// no write back.
							ctrl.jump_reg   = 1'b1;
						end
						default: begin
							ctrl         = '0;
							ctrl.illegal = 1'b1;	// unknown funct.
						end
					endcase
				end
				ADDI, ADDIU, SLTI, SLTIU: begin
					ctrl.alu_src_imm = 1'b1;
					ctrl.reg_write   = 1'b1;
					imm32            = imm_sext;
					if (if_id.opcode == SLTI)       ctrl.alu_op = ALU_SLT;
					else if (if_id.opcode == SLTIU) ctrl.alu_op = ALU_SLTU;
					else                            ctrl.alu_op = ALU_ADD;
				end
				ANDI, ORI, XORI: begin
					ctrl.alu_src_imm = 1'b1;
					ctrl.reg_write   = 1'b1;
					imm32            = imm_zext;	// logic ops do not sign extend.
					if (if_id.opcode == ANDI)     ctrl.alu_op = ALU_AND;
					else if (if_id.opcode == ORI) ctrl.alu_op = ALU_OR;
					else                          ctrl.alu_op = ALU_XOR;
				end
				LUI: begin
					ctrl.alu_src_imm = 1'b1;
					ctrl.reg_write   = 1'b1;
					ctrl.alu_op      = ALU_LUI;
					imm32            = {if_id.imm16, 16'h0000};
				end
				LW, SW: begin
					ctrl.alu_src_imm = 1'b1;	// base plus offset.
					ctrl.alu_op      = ALU_ADD;
					ctrl.mem_read    = (if_id.opcode == LW);
					ctrl.reg_write   = (if_id.opcode == LW);
					ctrl.mem_write   = (if_id.opcode == SW);
					imm32            = imm_sext;
				end
				BEQ, BNE: begin
					ctrl.branch    = 1'b1;
					ctrl.branch_ne = (if_id.opcode == BNE);
					ctrl.alu_op    = ALU_SUB;	// compare rs and rt.
					imm32          = imm_sext;	// word offset, shifted later.
				end
				J:    ctrl.jump = 1'b1;
				JAL: begin
					ctrl.jump      = 1'b1;
					ctrl.link      = 1'b1;
					ctrl.reg_write = 1'b1;
				end
				HALT: ctrl.halt = 1'b1;
				default: ctrl.illegal = 1'b1;	// opcode outside the table.
			endcase
		end
	end

endmodule

/* front_end.sv */
/*
  front end top level: fetch, the IF/ID register and decode.
  instruction memory is external, addressed through imem_addr.
*/
`timescale 1ns/1ns

module front_end
	import cpu_types_pkg::*;
(
	input  logic   CLK,
	input  logic   nRST,
	input  word_t  instruction,
	input  logic   ihit,
	input  logic   stall,
	input  logic   redirect,
	input  word_t  redirect_pc,
	output word_t  imem_addr,
	output if_id_t id_fields,
	output ctrl_t  id_ctrl,
	output word_t  id_imm
);

	logic  advance;	// load IF/ID with the fetched word.
	logic  flush;	// load IF/ID with a bubble.
	word_t pc_plus4;

	pc_fetch fetch0 (
		.CLK        (CLK),
		.nRST       (nRST),
		.ihit       (ihit),
		.stall      (stall),
		.redirect   (redirect),
		.redirect_pc(redirect_pc),
		.imem_addr  (imem_addr),
		.pc_plus4   (pc_plus4),
		.advance    (advance),
		.flush      (flush)
	);

	if_id_reg if_id0 (
		.CLK        (CLK),
		.nRST       (nRST),
		.advance    (advance),
		.flush      (flush),
		.instruction(instruction),
		.pc_plus4   (pc_plus4),
		.if_id      (id_fields)
	);

	control_decode decode0 (
		.if_id(id_fields),
		.ctrl (id_ctrl),
		.imm32(id_imm)
	);

endmodule

/* front_end_assert.sv */
/*
  concurrent checks on fetch and the IF/ID register, bound into front_end.
*/
`timescale 1ns/1ns

module front_end_assert
	import cpu_types_pkg::*;
(
	input logic   CLK,
	input logic   nRST,
	input logic   advance,
	input logic   flush,
	input word_t  imem_addr,
	input if_id_t id_fields
);

	// an accepted word enters as valid, so a load and a flush never act together.
	no_load_on_flush: assert property (@(posedge CLK) disable iff (!nRST)
		advance |=> id_fields.valid)
		else $error("accepted word not loaded as valid");

	// fetch addresses stay on word boundaries.
	addr_aligned: assert property (@(posedge CLK) disable iff (!nRST)
		imem_addr[1:0] == 2'b00)
		else $error("imem_addr not word aligned");

	// flushed entry is a bubble.
	bubble_after_flush: assert property (@(posedge CLK) disable iff (!nRST)
		flush |=> !id_fields.valid)
		else $error("valid set after flush");

endmodule

/* tb_front_end.sv */
/*
  random-stimulus testbench for the front end; a model of the PC, the IF/ID
  register and decode is checked against the DUT on every falling edge.
*/
`timescale 1ns/1ns
`include "cpu_settings.svh"

module tb_front_end
	import cpu_types_pkg::*;
;

	localparam int RESET_CYCLES = 8;
	localparam int TEST_CYCLES  = 2000;
	localparam int MAX_CYCLES   = TEST_CYCLES * 3 / 2;	// margin over the test length.

	logic   CLK;
	logic   nRST;
	word_t  instruction;
	logic   ihit;
	logic   stall;
	logic   redirect;
	word_t  redirect_pc;
	word_t  imem_addr;
	if_id_t id_fields;
	ctrl_t  id_ctrl;
	word_t  id_imm;

	integer seed = 32'ha86a_a821;
	int     cycles = 0;
	word_t  m_pc;	// model pc.
	if_id_t m_ifid;	// model IF/ID contents.

	// legal opcodes and functs in MIPS encoding.
	logic [5:0] op_tab [16] = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h05, 6'h08, 6'h09, 6'h0a,
		6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h23, 6'h2b, 6'h3f};
	logic [5:0] fn_tab [13] = '{6'h00, 6'h02, 6'h08, 6'h20, 6'h21, 6'h22, 6'h23, 6'h24,
		6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};

	front_end dut0 (.*);

	bind front_end front_end_assert assert0 (
		.CLK      (CLK),
		.nRST     (nRST),
		.advance  (advance),
		.flush    (flush),
		.imem_addr(imem_addr),
		.id_fields(id_fields)
	);

	always #4 CLK = ~CLK;	// 8 ns period.

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
			$display("Simulation failed");
			$fatal(1, "timeout");
		end
	end

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
			$display("Simulation failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic check_fields(input string name, input if_id_t exp, input if_id_t act);
		if (exp !== act) begin
			$display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
			$display("Simulation failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic check_ctrl(input string name, input ctrl_t exp, input ctrl_t act);
		if (exp !== act) begin
			$display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
			$display("Simulation failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	function automatic int unsigned pct();
		int unsigned r;
		r = $random(seed);
		return r % 100;
	endfunction

	// mostly legal opcode and funct with a few fully random words.
	function automatic word_t random_instruction();
		word_t w;
		int unsigned k;
		w = $random(seed);
		if (pct() >= 5) begin
			k = $random(seed);
			w[31:26] = op_tab[k % 16];
			if (w[31:26] == 6'h00)
				w[5:0] = fn_tab[(k >> 8) % 13];
		end
		return w;
	endfunction

	function automatic if_id_t make_fields(input word_t w, input word_t pc4);
		if_id_t f;
		f.valid    = 1'b1;
		f.opcode   = opcode_t'(w[31:26]);
		f.rs       = w[25:21];
		f.rt       = w[20:16];
		f.rd       = w[15:11];
		f.shamt    = w[10:6];
		f.funct    = funct_t'(w[5:0]);
		f.imm16    = w[15:0];
		f.jaddr26  = w[25:0];
		f.pc_plus4 = pc4;
		return f;
	endfunction

	function automatic ctrl_t expect_ctrl(input if_id_t f);
		ctrl_t c;
		logic [5:0] op;
		logic [5:0] fn;
		c  = '0;
		op = f.opcode;
		fn = f.funct;
		if (f.valid) begin
			case (op)
				6'h00: begin
					c.reg_dst_rd = 1'b1;
					c.reg_write  = 1'b1;
					case (fn)
						6'h00:        c.alu_op = ALU_SLL;
						6'h02:        c.alu_op = ALU_SRL;
						6'h20, 6'h21: c.alu_op = ALU_ADD;
						6'h22, 6'h23: c.alu_op = ALU_SUB;
						6'h24:        c.alu_op = ALU_AND;
						6'h25:        c.alu_op = ALU_OR;
						6'h26:        c.alu_op = ALU_XOR;
						6'h27:        c.alu_op = ALU_NOR;
						6'h2a:        c.alu_op = ALU_SLT;
						6'h2b:        c.alu_op = ALU_SLTU;
						6'h08: begin
							c = '0;
							c.jump_reg = 1'b1;	// jr writes nothing.
						end
						default: begin
							c = '0;
							c.illegal = 1'b1;
						end
					endcase
				end
				6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
					c.alu_src_imm = 1'b1;
					c.reg_write   = 1'b1;
					case (op)
						6'h0a:   c.alu_op = ALU_SLT;
						6'h0b:   c.alu_op = ALU_SLTU;
						6'h0c:   c.alu_op = ALU_AND;
						6'h0d:   c.alu_op = ALU_OR;
						6'h0e:   c.alu_op = ALU_XOR;
						6'h0f:   c.alu_op = ALU_LUI;
						default: c.alu_op = ALU_ADD;	// addi and addiu.
					endcase
				end
				6'h23: begin
					c.alu_src_imm = 1'b1;
					c.alu_op      = ALU_ADD;
					c.mem_read    = 1'b1;
					c.reg_write   = 1'b1;
				end
				6'h2b: begin
					c.alu_src_imm = 1'b1;
					c.alu_op      = ALU_ADD;
					c.mem_write   = 1'b1;
				end
				6'h04, 6'h05: begin
					c.branch    = 1'b1;
					c.branch_ne = (op == 6'h05);
					c.alu_op    = ALU_SUB;
				end
				6'h02: c.jump = 1'b1;
				6'h03: begin
					c.jump      = 1'b1;
					c.link      = 1'b1;
					c.reg_write = 1'b1;
				end
				6'h3f:   c.halt = 1'b1;
				default: c.illegal = 1'b1;
			endcase
		end
		return c;
	endfunction

	function automatic word_t expect_imm(input if_id_t f);
		logic [5:0] op;
		op = f.opcode;
		if (!f.valid)
			return '0;
		case (op)
			6'h04, 6'h05, 6'h08, 6'h09, 6'h0a, 6'h0b, 6'h23, 6'h2b:
				return {{16{f.imm16[15]}}, f.imm16};	// signed offset or constant.
			6'h0c, 6'h0d, 6'h0e: return {16'h0000, f.imm16};
			6'h0f:               return {f.imm16, 16'h0000};
			default:             return '0;
		endcase
	endfunction

	task automatic compare_outputs();
		check_word("imem_addr", m_pc, imem_addr);
		check_fields("id_fields", m_ifid, id_fields);
		check_ctrl("id_ctrl", expect_ctrl(m_ifid), id_ctrl);
		check_word("id_imm", expect_imm(m_ifid), id_imm);
	endtask

	task automatic drive_inputs();
		word_t t;
		t           = $random(seed);
		ihit        = (pct() < 75);
		stall       = (pct() < 20);
		redirect    = (pct() < 10);
		redirect_pc = {t[31:2], 2'b00};	// word aligned target.
		instruction = random_instruction();
	endtask

	// state after the next rising edge from the inputs now driven.
	task automatic model_step();
		if (redirect) begin
			m_pc          = redirect_pc;
			m_ifid        = '0;
			m_ifid.opcode = RTYPE;
			m_ifid.funct  = ADD;
		end else if (ihit && !stall) begin
			m_ifid = make_fields(instruction, m_pc + 32'd4);
			m_pc   = m_pc + 32'd4;
		end
	endtask

	initial begin
		CLK         = 1'b0;
		nRST        = 1'b0;
		instruction = '0;
		ihit        = 1'b0;
		stall       = 1'b0;
		redirect    = 1'b0;
		redirect_pc = '0;
		m_pc        = `RESET_PC;
		m_ifid      = '0;
		repeat (RESET_CYCLES) begin
			@(negedge CLK);
			compare_outputs();	// reset values held.
		end
		nRST = 1'b1;
		drive_inputs();
		model_step();
		repeat (TEST_CYCLES) begin
			@(negedge CLK);
			compare_outputs();
			drive_inputs();
			model_step();
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+.
cpu_types_pkg.sv
pc_fetch.sv
if_id_reg.sv
control_decode.sv
front_end.sv
front_end_assert.sv
tb_front_end.sv

/* run_sim.sh */
#!/bin/sh
# build the front end testbench with Verilator, run it, then scan the log.
verilator --binary --timing --assert -Wno-fatal --top-module tb_front_end -f vlog.f \
	-o sim_front_end > build.log 2>&1 || { echo "compile failed, see build.log"; exit 1; }
./obj_dir/sim_front_end > sim.log 2>&1 || { echo "simulation exited with an error, see sim.log"; exit 1; }
grep -q "Simulation failed" sim.log && { echo "FAIL, see sim.log"; exit 1; } || echo "PASS"
